// File: compile.f
verilog/tm_pkg.sv
verilog/tm_assoc_cfg.sv
verilog/tm_level_depth.sv
verilog/tm_poll_align.sv
verilog/tm_qm_poll.sv
verification/tm_qm_poll_assertions.sv
verification/tm_qm_poll_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal -f compile.f --top-module tm_qm_poll_tb -o tm_qm_poll_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tm_qm_poll_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$log"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// File: verification/tm_qm_poll_tb.sv
// ====================
// table-driven testbench for the queue manager poll unit
// fills the association table with random entries, then applies
// reads, polls, per-level drops and a poll burst from one row table
// ====================
`timescale 1ns/1ps

module tm_qm_poll_tb;
    import tm_pkg::*;

    localparam int clk_half    = 20;
    localparam int drive_delay = 2;
    localparam int wait_limit  = 20;
    localparam int qid_nbits   = level_id_nbits[0];
    localparam int conn_nbits  = level_id_nbits[1];
    localparam int group_nbits = level_id_nbits[2];
    localparam int pq_nbits    = level_id_nbits[3];
    localparam int num_queues  = 2 ** qid_nbits;
    localparam int thresh_open = (1 << depth_nbits) - 1;

    typedef logic [qid_nbits-1:0] id_t;
    typedef enum logic [2:0] {op_wr, op_rd, op_poll, op_enq, op_deq, op_burst} op_e;

    // data holds the expected word for reads
    typedef struct packed {
        op_e                       op;
        logic [reg_addr_nbits-1:0] addr;
        logic [reg_data_nbits-1:0] data;
        logic                      exp_drop;
        drop_cause_e               exp_cause;
    } row_t;

    logic                      clk;
    logic                      rst_n;
    logic                      poll_req;
    logic [qid_nbits-1:0]      poll_qid;
    logic                      enq_req;
    logic [qid_nbits-1:0]      enq_qid;
    logic [conn_nbits-1:0]     enq_conn_id;
    logic [group_nbits-1:0]    enq_group_id;
    logic [pq_nbits-1:0]       enq_port_queue_id;
    logic                      deq_req;
    logic [qid_nbits-1:0]      deq_qid;
    logic [conn_nbits-1:0]     deq_conn_id;
    logic [group_nbits-1:0]    deq_group_id;
    logic [pq_nbits-1:0]       deq_port_queue_id;
    logic                      reg_wr;
    logic                      reg_rd;
    logic [reg_addr_nbits-1:0] reg_addr;
    logic [reg_data_nbits-1:0] reg_din;
    logic                      poll_ack;
    logic                      poll_drop;
    drop_cause_e               poll_drop_cause;
    logic [conn_nbits-1:0]     poll_conn_id;
    logic [group_nbits-1:0]    poll_group_id;
    logic [pq_nbits-1:0]       poll_port_queue_id;
    logic [port_id_nbits-1:0]  poll_port_id;
    logic                      mem_ack;
    logic [reg_data_nbits-1:0] mem_rdata;

    row_t                   table_rows[$];
    string                  table_names[$];
    logic [assoc_nbits-1:0] assoc_mirror [num_queues];
    drop_cause_e            level_cause [num_levels] = '{cause_queue, cause_conn,
                                                          cause_group, cause_port};
    int                     seed = 32'h3eb1;
    int                     err_count = 0;
    int                     test_count = 0;
    int                     fail_count = 0;

    tm_qm_poll dut_i (.*);

    bind tm_qm_poll tm_qm_poll_assertions assertions_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .poll_req  (poll_req),
        .poll_ack  (poll_ack),
        .poll_drop (poll_drop),
        .reg_rd    (reg_rd),
        .mem_ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ====================
    // expected values
    // ====================
    // entry holds conn [3:0], group [6:4], port queue [8:7] and port [10:9]
    function automatic id_t level_id(input int q, input int lvl);
        logic [assoc_nbits-1:0] e;
        e = assoc_mirror[q];
        case (lvl)
            0: return id_t'(q);
            1: return id_t'(e[3:0]);
            2: return id_t'(e[6:4]);
            3: return id_t'(e[8:7]);
            default: return '0;
        endcase
    endfunction

    function automatic int other_queue(input int qa, input int lvl);
        for (int q = 0; q < num_queues; q++) begin
            if (level_id(q, lvl) != level_id(qa, lvl)) begin
                return q;
            end
        end
        return -1;
    endfunction

    task automatic check_data(input string name, input logic [reg_data_nbits-1:0] exp,
                              input logic [reg_data_nbits-1:0] act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_cause(input string name, input drop_cause_e exp,
                               input drop_cause_e act);
        if (act !== exp) begin
            $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
            err_count++;
        end
    endtask

    task automatic check_poll(input string name, input int q, input logic exp_drop,
                              input drop_cause_e exp_cause);
        check_flag({name, " drop"}, exp_drop, poll_drop);
        check_cause({name, " cause"}, exp_cause, poll_drop_cause);
        check_id({name, " conn"}, level_id(q, 1), id_t'(poll_conn_id));
        check_id({name, " group"}, level_id(q, 2), id_t'(poll_group_id));
        check_id({name, " port queue"}, level_id(q, 3), id_t'(poll_port_queue_id));
        check_id({name, " port"}, id_t'(assoc_mirror[q][10:9]), id_t'(poll_port_id));
    endtask

    // ====================
    // stimulus
    // ====================
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic wait_flag(input string name, ref logic flag, output int cycles);
        cycles = 0;
        while (flag !== 1'b1 && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (flag !== 1'b1) begin
            $display("%s: no acknowledge within %0d cycles", name, wait_limit);
            err_count++;
        end
    endtask

    task automatic drive_event(input op_e op, input int q);
        if (op == op_enq) begin
            enq_req           = 1'b1;
            enq_qid           = qid_nbits'(q);
            enq_conn_id       = conn_nbits'(level_id(q, 1));
            enq_group_id      = group_nbits'(level_id(q, 2));
            enq_port_queue_id = pq_nbits'(level_id(q, 3));
        end else begin
            deq_req           = 1'b1;
            deq_qid           = qid_nbits'(q);
            deq_conn_id       = conn_nbits'(level_id(q, 1));
            deq_group_id      = group_nbits'(level_id(q, 2));
            deq_port_queue_id = pq_nbits'(level_id(q, 3));
        end
        next_cycle();
        enq_req = 1'b0;
        deq_req = 1'b0;
    endtask

    task automatic run_row(input string name, input row_t r);
        int errs_before;
        int cycles;
        int q;
        errs_before = err_count;
        q = int'(r.addr);
        case (r.op)
            op_wr, op_rd: begin
                reg_wr   = (r.op == op_wr);
                reg_rd   = (r.op == op_rd);
                reg_addr = r.addr;
                reg_din  = r.data;
                next_cycle();
                reg_wr = 1'b0;
                reg_rd = 1'b0;
                if (r.op == op_rd) begin
                    wait_flag(name, mem_ack, cycles);
                    if (mem_ack === 1'b1 && cycles != 0) begin
                        $display("%s: mem_ack came %0d cycles late", name, cycles);
                        err_count++;
                    end
                    check_data(name, r.data, mem_rdata);
                end
            end
            op_poll: begin
                poll_req = 1'b1;
                poll_qid = qid_nbits'(q);
                next_cycle();
                poll_req = 1'b0;
                wait_flag(name, poll_ack, cycles);
                if (poll_ack === 1'b1) begin
                    if (cycles != 2) begin
                        $display("%s: poll_ack not 3 cycles after the request", name);
                        err_count++;
                    end
                    check_poll(name, q, r.exp_drop, r.exp_cause);
                end
            end
            op_enq, op_deq: begin
                drive_event(r.op, q);
            end
            op_burst: begin
                for (int i = 0; i < 3; i++) begin
                    poll_req = 1'b1;
                    poll_qid = qid_nbits'((q + i) % num_queues);
                    next_cycle();
                end
                poll_req = 1'b0;
                wait_flag(name, poll_ack, cycles);
                for (int i = 0; i < 3; i++) begin
                    if (poll_ack !== 1'b1) begin
                        $display("%s: ack %0d of the burst is missing", name, i);
                        err_count++;
                    end else begin
                        check_poll($sformatf("%s ack %0d", name, i), (q + i) % num_queues,
                                   1'b0, cause_none);
                    end
                    next_cycle();
                end
            end
            default: begin
                $display("%s: unknown table operation", name);
                err_count++;
            end
        endcase
        test_count++;
        if (err_count != errs_before) begin
            fail_count++;
        end
        $display("test %0d %s: %s", test_count, name,
                 (err_count == errs_before) ? "ok" : "failed");
    endtask

    task automatic add_row(input string name, input op_e op, input int addr, input int data,
                           input logic exp_drop, input drop_cause_e exp_cause);
        row_t r;
        r.op        = op;
        r.addr      = reg_addr_nbits'(addr);
        r.data      = reg_data_nbits'(data);
        r.exp_drop  = exp_drop;
        r.exp_cause = exp_cause;
        table_rows.push_back(r);
        table_names.push_back(name);
    endtask

    // ====================
    // table
    // ====================
    task automatic build_table();
        logic [31:0] val;
        int qa;
        int qb;
        for (int q = 0; q < num_queues; q++) begin
            val = $random(seed);
            assoc_mirror[q] = val[assoc_nbits-1:0];
            add_row($sformatf("write q%0d", q), op_wr, q, assoc_mirror[q], 1'b0, cause_none);
        end
        add_row("read threshold 0", op_rd, thresh_base_addr, thresh_open, 1'b0, cause_none);
        for (int q = 0; q < num_queues; q++) begin
            add_row($sformatf("read q%0d", q), op_rd, q, assoc_mirror[q], 1'b0, cause_none);
        end
        for (int q = 0; q < num_queues; q++) begin
            add_row($sformatf("poll q%0d", q), op_poll, q, 0, 1'b0, cause_none);
        end
        for (int lvl = 0; lvl < num_levels; lvl++) begin
            qa = 7 + 9 * lvl;
            qb = other_queue(qa, lvl);
            if (qb < 0) begin
                $display("no queue maps to another id than q%0d at level %0d", qa, lvl);
                err_count++;
                continue;
            end
            add_row($sformatf("level %0d threshold 2", lvl), op_wr, thresh_base_addr + lvl, 2,
                    1'b0, cause_none);
            add_row($sformatf("level %0d enqueue 1", lvl), op_enq, qa, 0, 1'b0, cause_none);
            add_row($sformatf("level %0d enqueue 2", lvl), op_enq, qa, 0, 1'b0, cause_none);
            add_row($sformatf("level %0d drop q%0d", lvl, qa), op_poll, qa, 0,
                    1'b1, level_cause[lvl]);
            add_row($sformatf("level %0d other q%0d", lvl, qb), op_poll, qb, 0,
                    1'b0, cause_none);
            add_row($sformatf("level %0d dequeue 1", lvl), op_deq, qa, 0, 1'b0, cause_none);
            add_row($sformatf("level %0d pass q%0d", lvl, qa), op_poll, qa, 0,
                    1'b0, cause_none);
            add_row($sformatf("level %0d dequeue 2", lvl), op_deq, qa, 0, 1'b0, cause_none);
            // one more dequeue at depth zero
            add_row($sformatf("level %0d dequeue empty", lvl), op_deq, qa, 0,
                    1'b0, cause_none);
            add_row($sformatf("level %0d empty q%0d", lvl, qa), op_poll, qa, 0,
                    1'b0, cause_none);
            add_row($sformatf("level %0d threshold open", lvl), op_wr, thresh_base_addr + lvl,
                    thresh_open, 1'b0, cause_none);
        end
        add_row("burst q10 to q12", op_burst, 10, 0, 1'b0, cause_none);
    endtask

    initial begin
        rst_n             = 1'b0;
        poll_req          = 1'b0;
        poll_qid          = '0;
        enq_req           = 1'b0;
        enq_qid           = '0;
        enq_conn_id       = '0;
        enq_group_id      = '0;
        enq_port_queue_id = '0;
        deq_req           = 1'b0;
        deq_qid           = '0;
        deq_conn_id       = '0;
        deq_group_id      = '0;
        deq_port_queue_id = '0;
        reg_wr            = 1'b0;
        reg_rd            = 1'b0;
        reg_addr          = '0;
        reg_din           = '0;
        build_table();
        repeat (8) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        next_cycle();
        foreach (table_rows[i]) begin
            run_row(table_names[i], table_rows[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", test_count, fail_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: verification/tm_qm_poll_assertions.sv
// ====================
// concurrent checks on the poll unit top level
// bound to every tm_qm_poll instance from the testbench
// ====================
`timescale 1ns/1ps

module tm_qm_poll_assertions (
    input logic clk,
    input logic rst_n,
    input logic poll_req,
    input logic poll_ack,
    input logic poll_drop,
    input logic reg_rd,
    input logic mem_ack
);

    // three cycles from request to answer
    poll_latency: assert property (@(posedge clk) disable iff (!rst_n)
        poll_ack == $past(poll_req, 3))
        else $error("poll_ack does not follow poll_req by exactly 3 cycles");

    read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack == $past(reg_rd))
        else $error("mem_ack does not follow reg_rd by 1 cycle");

    drop_needs_ack: assert property (@(posedge clk) disable iff (!rst_n)
        poll_drop |-> poll_ack)
        else $error("poll_drop high without poll_ack");

endmodule

// File: verilog/tm_qm_poll.sv
// ====================
// queue manager poll unit, top level
// lookup, per-level depth checks and answer merge, 3 cycles from poll_req
// enqueue and dequeue events keep the level depths current
// ====================
`timescale 1ns/1ps

module tm_qm_poll #(
    parameter int NUM_LEVELS  = tm_pkg::num_levels,
    parameter int DEPTH_NBITS = tm_pkg::depth_nbits
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 poll_req,
    input  logic [tm_pkg::level_id_nbits[0]-1:0] poll_qid,
    input  logic                                 enq_req,
    input  logic [tm_pkg::level_id_nbits[0]-1:0] enq_qid,
    input  logic [tm_pkg::level_id_nbits[1]-1:0] enq_conn_id,
    input  logic [tm_pkg::level_id_nbits[2]-1:0] enq_group_id,
    input  logic [tm_pkg::level_id_nbits[3]-1:0] enq_port_queue_id,
    input  logic                                 deq_req,
    input  logic [tm_pkg::level_id_nbits[0]-1:0] deq_qid,
    input  logic [tm_pkg::level_id_nbits[1]-1:0] deq_conn_id,
    input  logic [tm_pkg::level_id_nbits[2]-1:0] deq_group_id,
    input  logic [tm_pkg::level_id_nbits[3]-1:0] deq_port_queue_id,
    input  logic                                 reg_wr,
    input  logic                                 reg_rd,
    input  logic [tm_pkg::reg_addr_nbits-1:0]    reg_addr,
    input  logic [tm_pkg::reg_data_nbits-1:0]    reg_din,
    output logic                                 poll_ack,
    output logic                                 poll_drop,
    output tm_pkg::drop_cause_e                  poll_drop_cause,
    output logic [tm_pkg::level_id_nbits[1]-1:0] poll_conn_id,
    output logic [tm_pkg::level_id_nbits[2]-1:0] poll_group_id,
    output logic [tm_pkg::level_id_nbits[3]-1:0] poll_port_queue_id,
    output logic [tm_pkg::port_id_nbits-1:0]     poll_port_id,
    output logic                                 mem_ack,
    output logic [tm_pkg::reg_data_nbits-1:0]    mem_rdata
);
    import tm_pkg::*;

    // queue ids are the widest, other levels are zero extended
    localparam int id_nbits = level_id_nbits[0];

    logic                         lookup_valid;
    logic [level_id_nbits[0]-1:0] lookup_id0;
    logic [level_id_nbits[1]-1:0] lookup_id1;
    logic [level_id_nbits[2]-1:0] lookup_id2;
    logic [level_id_nbits[3]-1:0] lookup_id3;
    logic [port_id_nbits-1:0]     lookup_port;
    logic [DEPTH_NBITS-1:0]       thresh [NUM_LEVELS];
    logic [id_nbits-1:0]          enq_ids [NUM_LEVELS];
    logic [id_nbits-1:0]          deq_ids [NUM_LEVELS];
    logic [id_nbits-1:0]          check_ids [NUM_LEVELS];
    logic [NUM_LEVELS-1:0]        level_valid;
    logic [NUM_LEVELS-1:0]        level_drop;

    assign enq_ids[0] = enq_qid;
    assign enq_ids[1] = id_nbits'(enq_conn_id);
    assign enq_ids[2] = id_nbits'(enq_group_id);
    assign enq_ids[3] = id_nbits'(enq_port_queue_id);

    assign deq_ids[0] = deq_qid;
    assign deq_ids[1] = id_nbits'(deq_conn_id);
    assign deq_ids[2] = id_nbits'(deq_group_id);
    assign deq_ids[3] = id_nbits'(deq_port_queue_id);

    assign check_ids[0] = lookup_id0;
    assign check_ids[1] = id_nbits'(lookup_id1);
    assign check_ids[2] = id_nbits'(lookup_id2);
    assign check_ids[3] = id_nbits'(lookup_id3);

    tm_assoc_cfg #(.DEPTH_NBITS(DEPTH_NBITS)) assoc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .poll_req     (poll_req),
        .poll_qid     (poll_qid),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_din      (reg_din),
        .lookup_valid (lookup_valid),
        .lookup_id0   (lookup_id0),
        .lookup_id1   (lookup_id1),
        .lookup_id2   (lookup_id2),
        .lookup_id3   (lookup_id3),
        .lookup_port  (lookup_port),
        .thresh0      (thresh[0]),
        .thresh1      (thresh[1]),
        .thresh2      (thresh[2]),
        .thresh3      (thresh[3]),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    // ====================
    // level checkers
    // ====================
    for (genvar g = 0; g < NUM_LEVELS; g++) begin : g_level
        localparam int lvl_nbits = level_id_nbits[g];

        tm_level_depth #(.ID_NBITS(lvl_nbits), .DEPTH_NBITS(DEPTH_NBITS)) level_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .enq_req     (enq_req),
            .enq_id      (enq_ids[g][lvl_nbits-1:0]),
            .deq_req     (deq_req),
            .deq_id      (deq_ids[g][lvl_nbits-1:0]),
            .check_req   (lookup_valid),
            .check_id    (check_ids[g][lvl_nbits-1:0]),
            .threshold   (thresh[g]),
            .level_valid (level_valid[g]),
            .level_drop  (level_drop[g])
        );
    end

    tm_poll_align #(.NUM_LEVELS(NUM_LEVELS)) align_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .level_valid        (level_valid),
        .level_drop         (level_drop),
        .conn_id            (lookup_id1),
        .group_id           (lookup_id2),
        .port_queue_id      (lookup_id3),
        .port_id            (lookup_port),
        .poll_ack           (poll_ack),
        .poll_drop          (poll_drop),
        .poll_drop_cause    (poll_drop_cause),
        .poll_conn_id       (poll_conn_id),
        .poll_group_id      (poll_group_id),
        .poll_port_queue_id (poll_port_queue_id),
        .poll_port_id       (poll_port_id)
    );

endmodule

// File: verilog/tm_poll_align.sv
// ====================
// merges the level verdicts into the registered poll answer
// ids from the lookup are delayed to meet the verdicts of their poll
// ====================
`timescale 1ns/1ps

module tm_poll_align #(
    parameter int NUM_LEVELS = tm_pkg::num_levels
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [NUM_LEVELS-1:0]                level_valid,
    input  logic [NUM_LEVELS-1:0]                level_drop,
    input  logic [tm_pkg::level_id_nbits[1]-1:0] conn_id,
    input  logic [tm_pkg::level_id_nbits[2]-1:0] group_id,
    input  logic [tm_pkg::level_id_nbits[3]-1:0] port_queue_id,
    input  logic [tm_pkg::port_id_nbits-1:0]     port_id,
    output logic                                 poll_ack,
    output logic                                 poll_drop,
    output tm_pkg::drop_cause_e                  poll_drop_cause,
    output logic [tm_pkg::level_id_nbits[1]-1:0] poll_conn_id,
    output logic [tm_pkg::level_id_nbits[2]-1:0] poll_group_id,
    output logic [tm_pkg::level_id_nbits[3]-1:0] poll_port_queue_id,
    output logic [tm_pkg::port_id_nbits-1:0]     poll_port_id
);
    import tm_pkg::*;

    logic [level_id_nbits[1]-1:0] conn_d1;
    logic [level_id_nbits[2]-1:0] group_d1;
    logic [level_id_nbits[3]-1:0] port_queue_d1;
    logic [port_id_nbits-1:0]     port_d1;
    logic                         all_valid;
    drop_cause_e                  cause_next;

    assign all_valid = &level_valid;

    // lowest dropping level wins
    always_comb begin
        cause_next = cause_none;
        for (int i = NUM_LEVELS - 1; i >= 0; i--) begin
            if (level_drop[i]) begin
                cause_next = drop_cause_e'(3'(i));
            end
        end
    end

    // ====================
    // id delay and output stage
    // ====================
    always_ff @(posedge clk) begin
        conn_d1            <= conn_id;
        group_d1           <= group_id;
        port_queue_d1      <= port_queue_id;
        port_d1            <= port_id;
        poll_conn_id       <= conn_d1;
        poll_group_id      <= group_d1;
        poll_port_queue_id <= port_queue_d1;
        poll_port_id       <= port_d1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            poll_ack        <= 1'b0;
            poll_drop       <= 1'b0;
            poll_drop_cause <= cause_none;
        end else begin
            poll_ack        <= all_valid;
            poll_drop       <= all_valid && (|level_drop);
            poll_drop_cause <= all_valid ? cause_next : cause_none;
        end
    end

endmodule

// File: verilog/tm_level_depth.sv
// ====================
// depth counters and drop check for one hierarchy level
// one counter per id, kept by enqueue and dequeue events
// a check answers one cycle later against the depth at that edge
// ====================
`timescale 1ns/1ps

module tm_level_depth #(
    parameter int ID_NBITS    = tm_pkg::level_id_nbits[0],
    parameter int DEPTH_NBITS = tm_pkg::depth_nbits
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   enq_req,
    input  logic [ID_NBITS-1:0]    enq_id,
    input  logic                   deq_req,
    input  logic [ID_NBITS-1:0]    deq_id,
    input  logic                   check_req,
    input  logic [ID_NBITS-1:0]    check_id,
    input  logic [DEPTH_NBITS-1:0] threshold,
    output logic                   level_valid,
    output logic                   level_drop
);
    localparam int num_ids = 2 ** ID_NBITS;
    localparam logic [DEPTH_NBITS-1:0] depth_max = '1;

    logic [DEPTH_NBITS-1:0] depth_q [num_ids];
    logic [num_ids-1:0]     inc;
    logic [num_ids-1:0]     dec;

    // one-hot event per id
    always_comb begin
        inc = '0;
        dec = '0;
        if (enq_req) begin
            inc[enq_id] = 1'b1;
        end
        if (deq_req) begin
            dec[deq_id] = 1'b1;
        end
    end

    // ====================
    // saturating counters
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ids; i++) begin
                depth_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_ids; i++) begin
                // enq and deq on the same id cancel
                if (inc[i] && !dec[i] && depth_q[i] != depth_max) begin
                    depth_q[i] <= depth_q[i] + 1'b1;
                end else if (dec[i] && !inc[i] && depth_q[i] != '0) begin
                    depth_q[i] <= depth_q[i] - 1'b1;
                end
            end
        end
    end

    // drop check
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            level_valid <= 1'b0;
            level_drop  <= 1'b0;
        end else begin
            level_valid <= check_req;
            level_drop  <= check_req && (depth_q[check_id] >= threshold);
        end
    end

endmodule

// File: verilog/tm_assoc_cfg.sv
// ====================
// register port with the queue association table and level thresholds
// a poll looks up its queue here, one cycle before the level checks
// reads answer with mem_ack one cycle after reg_rd
// ====================
`timescale 1ns/1ps

module tm_assoc_cfg #(
    parameter int DEPTH_NBITS = tm_pkg::depth_nbits
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 poll_req,
    input  logic [tm_pkg::level_id_nbits[0]-1:0] poll_qid,
    input  logic                                 reg_wr,
    input  logic                                 reg_rd,
    input  logic [tm_pkg::reg_addr_nbits-1:0]    reg_addr,
    input  logic [tm_pkg::reg_data_nbits-1:0]    reg_din,
    output logic                                 lookup_valid,
    output logic [tm_pkg::level_id_nbits[0]-1:0] lookup_id0,
    output logic [tm_pkg::level_id_nbits[1]-1:0] lookup_id1,
    output logic [tm_pkg::level_id_nbits[2]-1:0] lookup_id2,
    output logic [tm_pkg::level_id_nbits[3]-1:0] lookup_id3,
    output logic [tm_pkg::port_id_nbits-1:0]     lookup_port,
    output logic [DEPTH_NBITS-1:0]               thresh0,
    output logic [DEPTH_NBITS-1:0]               thresh1,
    output logic [DEPTH_NBITS-1:0]               thresh2,
    output logic [DEPTH_NBITS-1:0]               thresh3,
    output logic                                 mem_ack,
    output logic [tm_pkg::reg_data_nbits-1:0]    mem_rdata
);
    import tm_pkg::*;

    localparam int qid_nbits = level_id_nbits[0];
    localparam int idx_nbits = $clog2(num_levels);
    localparam int group_lsb = level_id_nbits[1];
    localparam int pq_lsb = group_lsb + level_id_nbits[2];
    localparam int port_lsb = pq_lsb + level_id_nbits[3];

    logic [assoc_nbits-1:0]    assoc_mem [2 ** qid_nbits];
    logic [DEPTH_NBITS-1:0]    thresh_q [num_levels];
    logic [assoc_nbits-1:0]    entry_q;
    logic [reg_addr_nbits-1:0] thresh_off;
    logic [idx_nbits-1:0]      thresh_idx;
    reg_target_e               target;

    // ====================
    // address decode
    // ====================
    always_comb begin
        if (reg_addr < reg_addr_nbits'(thresh_base_addr)) begin
            target = target_assoc;
        end else if (reg_addr < reg_addr_nbits'(thresh_base_addr + num_levels)) begin
            target = target_thresh;
        end else begin
            target = target_none;
        end
    end

    assign thresh_off = reg_addr - reg_addr_nbits'(thresh_base_addr);
    assign thresh_idx = thresh_off[idx_nbits-1:0];

    // table and lookup entry
    always_ff @(posedge clk) begin
        if (reg_wr && target == target_assoc) begin
            assoc_mem[reg_addr[qid_nbits-1:0]] <= reg_din[assoc_nbits-1:0];
        end
        if (poll_req) begin
            entry_q    <= assoc_mem[poll_qid];
            lookup_id0 <= poll_qid;
        end
    end

    // thresholds open fully after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_levels; i++) begin
                thresh_q[i] <= '1;
            end
        end else if (reg_wr && target == target_thresh) begin
            thresh_q[thresh_idx] <= reg_din[DEPTH_NBITS-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_valid <= 1'b0;
            mem_ack      <= 1'b0;
        end else begin
            lookup_valid <= poll_req;
            mem_ack      <= reg_rd;
        end
    end

    // ====================
    // read data
    // ====================
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            case (target)
                target_assoc:  mem_rdata <= reg_data_nbits'(assoc_mem[reg_addr[qid_nbits-1:0]]);
                target_thresh: mem_rdata <= reg_data_nbits'(thresh_q[thresh_idx]);
                default:       mem_rdata <= '0;
            endcase
        end
    end

    assign lookup_id1 = entry_q[group_lsb-1:0];
    assign lookup_id2 = entry_q[pq_lsb-1:group_lsb];
    assign lookup_id3 = entry_q[port_lsb-1:pq_lsb];
    assign lookup_port = entry_q[assoc_nbits-1:port_lsb];

    assign thresh0 = thresh_q[0];
    assign thresh1 = thresh_q[1];
    assign thresh2 = thresh_q[2];
    assign thresh3 = thresh_q[3];

endmodule

// File: verilog/tm_pkg.sv
// ====================
// shared widths, register map and enums for the queue manager poll unit
// compile this package ahead of every module of the unit
// ====================
package tm_pkg;

    // ====================
    // hierarchy levels
    // ====================
    // queue, connection, connection group, port queue
    localparam int num_levels = 4;
    localparam int level_id_nbits [num_levels] = '{6, 4, 3, 2};
    localparam int port_id_nbits = 2;
    localparam int depth_nbits = 7;

    // association entry from bit 0 up: conn, group, port queue, port
    localparam int assoc_nbits = level_id_nbits[1] + level_id_nbits[2] +
                                 level_id_nbits[3] + port_id_nbits;

    // ====================
    // register port
    // ====================
    localparam int reg_addr_nbits = 7;
    localparam int reg_data_nbits = 16;
    // thresholds follow the 64 association entries
    localparam int thresh_base_addr = 64;

    typedef enum logic [1:0] {
        target_assoc,
        target_thresh,
        target_none
    } reg_target_e;

    // level that caused a drop, in level order
    typedef enum logic [2:0] {
        cause_queue,
        cause_conn,
        cause_group,
        cause_port,
        cause_none
    } drop_cause_e;

endpackage
